/* rtl/bbc_mem_pkg.sv */
package bbc_mem_pkg;

	localparam int cpu_addr_w = 16;
	localparam int sdram_addr_w = 25;

	typedef logic [7:0] byte_t;
	typedef logic [cpu_addr_w-1:0] cpu_addr_t;
	typedef logic [sdram_addr_w-1:0] sdram_addr_t;
	typedef logic [7:0] romsel_t;

	// download targets in sdram
	localparam sdram_addr_t rom_base_b = 25'h080000;
	localparam sdram_addr_t rom_base_other = 25'h068000;

	// sdram layout seen from the core
	localparam sdram_addr_t os_rom_base = 25'h080000;
	localparam sdram_addr_t model_b_rom_base = 25'h090000;
	localparam sdram_addr_t sideways_ram_base = 25'h040000;
	localparam sdram_addr_t filing_ram_base = 25'h00a000;

	// hold lengths in clk_48m cycles
	localparam int unsigned remap_hold = 4095;
	localparam int unsigned autoboot_hold_default = 32000000;

	// this index goes to the cmos ram, never to sdram
	localparam byte_t cmos_index = 8'hff;

	typedef enum logic [2:0] {
		region_video,
		region_ram,
		region_filing,
		region_os_rom,
		region_model_b_rom,
		region_master_rom,
		region_sideways_ram
	} mem_region_e;

	typedef enum logic [1:0] {
		target_rom_b,
		target_rom_other,
		target_cmos
	} dl_target_e;

	typedef struct packed {
		sdram_addr_t addr;
		logic        we;
		byte_t       data;
	} sdram_req_t;

endpackage

/* rtl/cpu_bus_if.sv */
`timescale 1ns/1ps

interface cpu_bus_if;

	bbc_mem_pkg::cpu_addr_t adr;
	bbc_mem_pkg::romsel_t   romsel;
	logic                   acc_y;
	logic                   shadow_ram;
	logic                   shadow_vid;
	logic                   phi0;
	logic                   we;
	bbc_mem_pkg::byte_t     dout;

	// driven by the core side
	modport core (output adr, romsel, acc_y, shadow_ram, shadow_vid, phi0, we, dout);

	modport mapper (input adr, romsel, acc_y, shadow_ram, shadow_vid, phi0, we, dout);

endinterface

/* rtl/cpu_addr_map.sv */
`timescale 1ns/1ps

module cpu_addr_map (
	cpu_bus_if.mapper                bus,
	input  logic                     model,
	input  logic                     rommap,
	output bbc_mem_pkg::sdram_req_t  cpu_req
);

	bbc_mem_pkg::mem_region_e region;
	bbc_mem_pkg::sdram_addr_t map_addr;
	logic [1:0] bank_grp;
	logic sideways_rom;
	logic writable;

	assign bank_grp = bus.romsel[3:2];

	// master has banks 0-3 and 8-f as rom
	// rommap set means low mapping on the model b
	always_comb begin
		if (model)
			sideways_rom = (bank_grp == 2'b00) || bank_grp[1];
		else if (rommap)
			sideways_rom = (bank_grp == 2'b00);
		else
			sideways_rom = (bank_grp == 2'b11);
	end

	// first match wins
	always_comb begin
		if (!bus.phi0)
			region = bbc_mem_pkg::region_video;
		else if (!bus.adr[15] || (bus.adr[15:12] == 4'h8 && bus.romsel[7]))
			region = bbc_mem_pkg::region_ram;
		else if (bus.adr[15:13] == 3'b110 && bus.acc_y)
			region = bbc_mem_pkg::region_filing;
		else if (bus.adr[15:14] == 2'b11)
			region = bbc_mem_pkg::region_os_rom;
		else if (sideways_rom && !model)
			region = bbc_mem_pkg::region_model_b_rom;
		else if (sideways_rom)
			region = bbc_mem_pkg::region_master_rom;
		else
			region = bbc_mem_pkg::region_sideways_ram;
	end

	always_comb begin
		case (region)
			bbc_mem_pkg::region_video:
				map_addr = bbc_mem_pkg::sdram_addr_t'({bus.shadow_vid, bus.adr});
			bbc_mem_pkg::region_ram:
				map_addr = bbc_mem_pkg::sdram_addr_t'({bus.shadow_ram, bus.adr});
			bbc_mem_pkg::region_filing:
				map_addr = bbc_mem_pkg::filing_ram_base +
					bbc_mem_pkg::sdram_addr_t'(bus.adr[12:0]);
			bbc_mem_pkg::region_os_rom:
				map_addr = bbc_mem_pkg::os_rom_base +
					bbc_mem_pkg::sdram_addr_t'({model, bus.adr[13:0]});
			bbc_mem_pkg::region_model_b_rom:
				map_addr = bbc_mem_pkg::model_b_rom_base +
					bbc_mem_pkg::sdram_addr_t'({bus.romsel[1:0], bus.adr[13:0]});
			// 64k per bank group starting at a0000
			bbc_mem_pkg::region_master_rom:
				map_addr = bbc_mem_pkg::sdram_addr_t'(
					{4'ha + {2'b00, bank_grp}, bus.romsel[1:0], bus.adr[13:0]});
			bbc_mem_pkg::region_sideways_ram:
				map_addr = bbc_mem_pkg::sideways_ram_base +
					bbc_mem_pkg::sdram_addr_t'({bus.romsel[3:0], bus.adr[13:0]});
			default:
				map_addr = '0;
		endcase
	end

	// only banks 4-7 of sideways ram take writes
	always_comb begin
		case (region)
			bbc_mem_pkg::region_ram,
			bbc_mem_pkg::region_filing:
				writable = 1'b1;
			bbc_mem_pkg::region_sideways_ram:
				writable = (bank_grp == 2'b01);
			default:
				writable = 1'b0;
		endcase
	end

	assign cpu_req = '{addr: map_addr, we: bus.we && writable, data: bus.dout};

endmodule

/* rtl/rom_loader.sv */
`timescale 1ns/1ps

module rom_loader (
	input  logic                     clk_48m,
	input  logic                     reset,
	input  logic                     mem_sync,
	input  logic                     ioctl_download,
	input  logic                     ioctl_wr,
	input  bbc_mem_pkg::byte_t       ioctl_index,
	input  bbc_mem_pkg::sdram_addr_t ioctl_addr,
	input  bbc_mem_pkg::byte_t       ioctl_data,
	output bbc_mem_pkg::sdram_req_t  load_req
);

	bbc_mem_pkg::dl_target_e target;
	bbc_mem_pkg::sdram_addr_t base;
	bbc_mem_pkg::sdram_addr_t addr_q;
	bbc_mem_pkg::byte_t data_q;
	logic wr_pending;
	logic we_q;

	always_comb begin
		if (ioctl_index == bbc_mem_pkg::cmos_index)
			target = bbc_mem_pkg::target_cmos;
		else if (ioctl_index == 8'h00)
			target = bbc_mem_pkg::target_rom_b;
		else
			target = bbc_mem_pkg::target_rom_other;
	end

	assign base = (target == bbc_mem_pkg::target_rom_b) ?
		bbc_mem_pkg::rom_base_b : bbc_mem_pkg::rom_base_other;

	// strobes within one slot merge into a single write
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			wr_pending <= 1'b0;
			we_q <= 1'b0;
		end else begin
			if (mem_sync) begin
				wr_pending <= 1'b0;
				we_q <= wr_pending;
			end
			if (ioctl_wr && ioctl_download && target != bbc_mem_pkg::target_cmos)
				wr_pending <= 1'b1;
		end
	end

	always_ff @(posedge clk_48m) begin
		if (mem_sync && wr_pending) begin
			addr_q <= ioctl_addr + base;
			data_q <= ioctl_data;
		end
	end

	assign load_req = '{addr: addr_q, we: we_q, data: data_q};

endmodule

/* rtl/sdram_request_port.sv */
`timescale 1ns/1ps

module sdram_request_port (
	input  logic                     clk_48m,
	input  logic                     reset,
	input  logic                     mem_sync,
	input  logic                     ioctl_download,
	input  bbc_mem_pkg::sdram_req_t  cpu_req,
	input  bbc_mem_pkg::sdram_req_t  load_req,
	output bbc_mem_pkg::sdram_addr_t sdram_addr,
	output logic                     sdram_we,
	output bbc_mem_pkg::byte_t       sdram_din
);

	bbc_mem_pkg::sdram_req_t sel_req;

	// download owns the slot while it runs
	assign sel_req = ioctl_download ? load_req : cpu_req;

	always_ff @(posedge clk_48m) begin
		if (reset)
			sdram_we <= 1'b0;
		else if (mem_sync)
			sdram_we <= sel_req.we;
	end

	always_ff @(posedge clk_48m) begin
		if (mem_sync) begin
			sdram_addr <= sel_req.addr;
			sdram_din <= sel_req.data;
		end
	end

endmodule

/* rtl/reset_sequencer.sv */
`timescale 1ns/1ps

module reset_sequencer #(
	parameter int unsigned autoboot_cycles = bbc_mem_pkg::autoboot_hold_default
) (
	input  logic clk_48m,
	input  logic reset,
	input  logic mem_sync,
	input  logic sdram_ready,
	input  logic user_reset,
	input  logic ioctl_download,
	input  logic model,
	input  logic rommap,
	input  logic autoboot,
	output logic cpu_reset,
	output logic shift_key
);

	localparam int remap_w = $clog2(bbc_mem_pkg::remap_hold + 1);
	localparam int boot_w = $clog2(autoboot_cycles + 1);

	logic last_model;
	logic last_rommap;
	logic setting_changed;
	logic [remap_w-1:0] remap_cnt;
	logic remap_reset;
	logic reset_in;
	logic [boot_w-1:0] boot_cnt;

	assign setting_changed = (last_model != model) || (last_rommap != rommap);

	// restart the core cleanly after a model or rom mapping change
	always_ff @(posedge clk_48m) begin
		last_model <= model;
		last_rommap <= rommap;
		if (reset)
			remap_cnt <= '0;
		else if (setting_changed)
			remap_cnt <= remap_w'(bbc_mem_pkg::remap_hold);
		else if (remap_cnt != '0)
			remap_cnt <= remap_cnt - 1'b1;
	end

	assign remap_reset = setting_changed || (remap_cnt != '0);

	assign reset_in = reset || !sdram_ready || user_reset || ioctl_download || remap_reset;

	// core reset only moves on slot boundaries
	always_ff @(posedge clk_48m) begin
		if (reset)
			cpu_reset <= 1'b1;
		else if (mem_sync)
			cpu_reset <= reset_in;
	end

	// hold shift after reset so the machine boots from disc
	always_ff @(posedge clk_48m) begin
		if (reset || cpu_reset)
			boot_cnt <= boot_w'(autoboot_cycles);
		else if (boot_cnt != '0)
			boot_cnt <= boot_cnt - 1'b1;
	end

	assign shift_key = autoboot && (boot_cnt != '0);

endmodule

/* rtl/bbc_mem_top.sv */
`timescale 1ns/1ps

module bbc_mem_top #(
	parameter int unsigned autoboot_cycles = bbc_mem_pkg::autoboot_hold_default
) (
	input  logic                     clk_48m,
	input  logic                     reset,
	input  logic                     mem_sync,
	input  logic                     sdram_ready,
	input  logic                     user_reset,
	input  logic                     phi0,
	input  bbc_mem_pkg::cpu_addr_t   mem_adr,
	input  bbc_mem_pkg::romsel_t     mem_romsel,
	input  logic                     mem_acc_y,
	input  logic                     shadow_ram,
	input  logic                     shadow_vid,
	input  logic                     mem_we,
	input  bbc_mem_pkg::byte_t       mem_do,
	input  logic                     model,
	input  logic                     rommap,
	input  logic                     autoboot,
	input  logic                     ioctl_download,
	input  logic                     ioctl_wr,
	input  bbc_mem_pkg::byte_t       ioctl_index,
	input  bbc_mem_pkg::sdram_addr_t ioctl_addr,
	input  bbc_mem_pkg::byte_t       ioctl_data,
	output bbc_mem_pkg::sdram_addr_t sdram_addr,
	output logic                     sdram_we,
	output bbc_mem_pkg::byte_t       sdram_din,
	output logic                     cpu_reset,
	output logic                     shift_key
);

	bbc_mem_pkg::sdram_req_t cpu_req;
	bbc_mem_pkg::sdram_req_t load_req;

	cpu_bus_if cpu_bus_i ();

	// core side of the bus
	assign cpu_bus_i.adr = mem_adr;
	assign cpu_bus_i.romsel = mem_romsel;
	assign cpu_bus_i.acc_y = mem_acc_y;
	assign cpu_bus_i.shadow_ram = shadow_ram;
	assign cpu_bus_i.shadow_vid = shadow_vid;
	assign cpu_bus_i.phi0 = phi0;
	assign cpu_bus_i.we = mem_we;
	assign cpu_bus_i.dout = mem_do;

	cpu_addr_map cpu_addr_map_i (
		.bus     (cpu_bus_i.mapper),
		.model   (model),
		.rommap  (rommap),
		.cpu_req (cpu_req)
	);

	rom_loader rom_loader_i (
		.clk_48m        (clk_48m),
		.reset          (reset),
		.mem_sync       (mem_sync),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.load_req       (load_req)
	);

	sdram_request_port sdram_request_port_i (
		.clk_48m        (clk_48m),
		.reset          (reset),
		.mem_sync       (mem_sync),
		.ioctl_download (ioctl_download),
		.cpu_req        (cpu_req),
		.load_req       (load_req),
		.sdram_addr     (sdram_addr),
		.sdram_we       (sdram_we),
		.sdram_din      (sdram_din)
	);

	reset_sequencer #(
		.autoboot_cycles (autoboot_cycles)
	) reset_sequencer_i (
		.clk_48m        (clk_48m),
		.reset          (reset),
		.mem_sync       (mem_sync),
		.sdram_ready    (sdram_ready),
		.user_reset     (user_reset),
		.ioctl_download (ioctl_download),
		.model          (model),
		.rommap         (rommap),
		.autoboot       (autoboot),
		.cpu_reset      (cpu_reset),
		.shift_key      (shift_key)
	);

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_48m,
	output logic reset
);

	initial begin
		clk_48m = 1'b0;
		forever #50 clk_48m = ~clk_48m;
	end

	// held for three rising edges, then released on an edge
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk_48m);
		reset <= 1'b0;
	end

endmodule

/* verification/bbc_mem_sva.sv */
`timescale 1ns/1ps

module bbc_mem_sva (
	input logic                     clk_48m,
	input logic                     reset,
	input logic                     mem_sync,
	input bbc_mem_pkg::sdram_addr_t watch_addr,
	input logic                     watch_we,
	input logic                     watch_rst
);

	// request outputs move only on the edge after a slot pulse
	assert property (@(posedge clk_48m) disable iff (reset)
		!$past(reset) && !$past(mem_sync) |-> $stable(watch_addr) && $stable(watch_we))
		else $error("sdram request changed outside a memory slot");

	assert property (@(posedge clk_48m) disable iff (reset)
		!$past(reset) && !$past(mem_sync) |-> $stable(watch_rst))
		else $error("cpu_reset changed outside a memory slot");

	assert property (@(posedge clk_48m) reset && $past(reset) |-> !watch_we)
		else $error("sdram_we high during reset");

endmodule

bind sdram_request_port bbc_mem_sva port_sva_i (
	.clk_48m    (clk_48m),
	.reset      (reset),
	.mem_sync   (mem_sync),
	.watch_addr (sdram_addr),
	.watch_we   (sdram_we),
	.watch_rst  (1'b0)
);

bind reset_sequencer bbc_mem_sva seq_sva_i (
	.clk_48m    (clk_48m),
	.reset      (reset),
	.mem_sync   (mem_sync),
	.watch_addr ('0),
	.watch_we   (1'b0),
	.watch_rst  (cpu_reset)
);

/* verification/bbc_mem_tb.sv */
`timescale 1ns/1ps

module bbc_mem_tb;

	localparam int max_vec = 64;
	localparam int rand_count = 32;
	localparam int autoboot_len = 64;
	localparam int test_len = 1200 + max_vec * 12 + rand_count * 12 +
		2 * (bbc_mem_pkg::remap_hold + 120) + 6 * autoboot_len;
	localparam int run_limit = 2 * test_len;

	logic clk_48m, reset, mem_sync, sdram_ready, user_reset, phi0;
	bbc_mem_pkg::cpu_addr_t mem_adr;
	bbc_mem_pkg::romsel_t mem_romsel;
	logic mem_acc_y, shadow_ram, shadow_vid, mem_we;
	bbc_mem_pkg::byte_t mem_do;
	logic model, rommap, autoboot, ioctl_download, ioctl_wr;
	bbc_mem_pkg::byte_t ioctl_index, ioctl_data, sdram_din;
	bbc_mem_pkg::sdram_addr_t ioctl_addr, sdram_addr;
	logic sdram_we, cpu_reset, shift_key;

	logic [31:0] vec_mem [0:8*max_vec-1];
	logic [1:0] phase = 2'd0;
	logic [15:0] lfsr = 16'd52462;
	int cycles = 0;
	int errors = 0;
	int tests = 0;
	int failed_tests = 0;
	int test_start_errors = 0;

	tb_clock_gen clock_gen_i (.clk_48m(clk_48m), .reset(reset));

	bbc_mem_top #(.autoboot_cycles(autoboot_len)) bbc_mem_top_i (.*);

	// slot pulse one cycle in four
	always @(posedge clk_48m) begin
		phase <= phase + 2'd1;
		mem_sync <= (phase == 2'd2);
	end

	always @(posedge clk_48m) begin
		cycles <= cycles + 1;
		if (cycles > run_limit) begin
			$display("timeout: run did not finish within %0d cycles", run_limit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic check_addr(input string name, input bbc_mem_pkg::sdram_addr_t got,
			input bbc_mem_pkg::sdram_addr_t exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_we(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_byte(input string name, input bbc_mem_pkg::byte_t got,
			input bbc_mem_pkg::byte_t exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic begin_test();
		test_start_errors = errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_start_errors) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: failed with %0d errors", name, errors - test_start_errors);
		end
	endtask

	// returns on a rising edge where the slot pulse is sampled
	task automatic next_slot();
		do @(posedge clk_48m); while (!mem_sync);
	endtask

	task automatic wait_cpu_reset(input logic level, input int max_cycles);
		int n;
		n = 0;
		@(negedge clk_48m);
		while (cpu_reset !== level && n < max_cycles) begin
			@(negedge clk_48m);
			n++;
		end
		if (cpu_reset !== level) begin
			$display("cpu_reset did not reach %0b within %0d cycles", level, max_cycles);
			errors++;
		end
	endtask

	// Fibonacci lfsr with taps 16 14 13 11
	function automatic logic [31:0] rand_bits(input int n);
		logic fb;
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic drive_core(input logic [7:0] fl, input logic [15:0] adr,
			input logic [7:0] sel, input logic [7:0] data);
		phi0 <= fl[7];
		mem_acc_y <= fl[6];
		shadow_ram <= fl[5];
		shadow_vid <= fl[4];
		mem_we <= fl[3];
		model <= fl[1];
		rommap <= fl[0];
		mem_adr <= adr;
		mem_romsel <= sel;
		mem_do <= data;
	endtask

	// expected core request from the memory map rules
	function automatic bbc_mem_pkg::sdram_req_t ref_map(input logic [7:0] fl,
			input logic [15:0] a, input logic [7:0] rs, input logic [7:0] d);
		bbc_mem_pkg::sdram_req_t r;
		logic [24:0] lo14;
		logic rom_ok;
		logic wr;
		lo14 = {11'd0, a[13:0]};
		wr = 1'b0;
		r.data = d;
		if (!fl[7]) begin
			r.addr = {8'd0, fl[4], a};
		end else if (a < 16'h8000 || (a <= 16'h8fff && rs[7])) begin
			r.addr = {8'd0, fl[5], a};
			wr = 1'b1;
		end else if (a >= 16'hc000 && a <= 16'hdfff && fl[6]) begin
			r.addr = bbc_mem_pkg::filing_ram_base + {12'd0, a[12:0]};
			wr = 1'b1;
		end else if (a >= 16'hc000) begin
			r.addr = bbc_mem_pkg::os_rom_base + (fl[1] ? 25'h4000 : 25'h0) + lo14;
		end else begin
			if (fl[1])
				rom_ok = (rs[3:2] == 2'b00) || rs[3];
			else
				rom_ok = fl[0] ? (rs[3:2] == 2'b00) : (rs[3:2] == 2'b11);
			if (rom_ok && fl[1])
				r.addr = (25'ha + 25'(rs[3:2])) * 25'h10000 + 25'(rs[1:0]) * 25'h4000 + lo14;
			else if (rom_ok)
				r.addr = bbc_mem_pkg::model_b_rom_base + 25'(rs[1:0]) * 25'h4000 + lo14;
			else begin
				r.addr = bbc_mem_pkg::sideways_ram_base + 25'(rs[3:0]) * 25'h4000 + lo14;
				wr = (rs[3:2] == 2'b01);
			end
		end
		r.we = fl[3] && wr;
		return r;
	endfunction

	task automatic run_core_vector(input logic [7:0] fl, input logic [15:0] adr,
			input logic [7:0] sel, input logic [7:0] data, input logic [24:0] exp_addr,
			input logic exp_we, input logic [7:0] exp_data);
		next_slot();
		drive_core(fl, adr, sel, data);
		next_slot();
		@(negedge clk_48m);
		check_addr("sdram_addr", sdram_addr, exp_addr);
		check_we("sdram_we", sdram_we, exp_we);
		check_byte("sdram_din", sdram_din, exp_data);
	endtask

	task automatic run_load_vector(input logic [7:0] idx, input logic [24:0] addr,
			input logic [7:0] data, input logic [24:0] exp_addr, input logic exp_we,
			input logic [7:0] exp_data);
		next_slot();
		ioctl_download <= 1'b1;
		ioctl_wr <= 1'b1;
		ioctl_index <= idx;
		ioctl_addr <= addr;
		ioctl_data <= data;
		@(posedge clk_48m);
		ioctl_wr <= 1'b0;
		next_slot();
		next_slot();
		@(negedge clk_48m);
		check_we("sdram_we", sdram_we, exp_we);
		if (exp_we) begin
			check_addr("sdram_addr", sdram_addr, exp_addr);
			check_byte("sdram_din", sdram_din, exp_data);
		end
		next_slot();
		@(negedge clk_48m);
		check_we("sdram_we", sdram_we, 1'b0);
	endtask

	initial begin
		logic [31:0] v;
		bbc_mem_pkg::sdram_req_t r;
		int i;
		sdram_ready = 1'b0;
		user_reset = 1'b0;
		mem_sync = 1'b0;
		phi0 = 1'b1;
		mem_adr = '0;
		mem_romsel = '0;
		mem_acc_y = 1'b0;
		shadow_ram = 1'b0;
		shadow_vid = 1'b0;
		mem_we = 1'b0;
		mem_do = '0;
		model = 1'b0;
		rommap = 1'b1;
		autoboot = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_data = '0;
		$readmemh("verification/bbc_mem_testdata.txt", vec_mem);
		@(negedge clk_48m);
		while (reset) @(negedge clk_48m);

		begin_test();
		check_we("cpu_reset", cpu_reset, 1'b1);
		check_we("sdram_we", sdram_we, 1'b0);
		repeat (3) next_slot();
		@(negedge clk_48m);
		check_we("cpu_reset", cpu_reset, 1'b1);
		@(posedge clk_48m);
		sdram_ready <= 1'b1;
		wait_cpu_reset(1'b0, 40);
		check_we("shift_key", shift_key, 1'b1);
		repeat (70) @(negedge clk_48m);
		check_we("shift_key", shift_key, 1'b0);
		end_test("reset release and autoboot");

		begin_test();
		@(posedge clk_48m);
		user_reset <= 1'b1;
		wait_cpu_reset(1'b1, 4);
		@(posedge clk_48m);
		user_reset <= 1'b0;
		wait_cpu_reset(1'b0, 16);
		@(posedge clk_48m);
		sdram_ready <= 1'b0;
		wait_cpu_reset(1'b1, 4);
		@(posedge clk_48m);
		sdram_ready <= 1'b1;
		wait_cpu_reset(1'b0, 16);
		@(posedge clk_48m);
		ioctl_download <= 1'b1;
		wait_cpu_reset(1'b1, 4);
		@(posedge clk_48m);
		ioctl_download <= 1'b0;
		wait_cpu_reset(1'b0, 16);
		end_test("reset sources");

		begin_test();
		@(posedge clk_48m);
		autoboot <= 1'b0;
		user_reset <= 1'b1;
		wait_cpu_reset(1'b1, 4);
		@(posedge clk_48m);
		user_reset <= 1'b0;
		wait_cpu_reset(1'b0, 16);
		check_we("shift_key", shift_key, 1'b0);
		repeat (20) @(negedge clk_48m);
		check_we("shift_key", shift_key, 1'b0);
		end_test("autoboot clear");

		begin_test();
		i = 0;
		while (i < max_vec && vec_mem[8*i] != 32'hf) begin
			if (vec_mem[8*i] == 32'h0)
				run_core_vector(vec_mem[8*i+1][7:0], vec_mem[8*i+2][15:0],
					vec_mem[8*i+3][7:0], vec_mem[8*i+4][7:0], vec_mem[8*i+5][24:0],
					vec_mem[8*i+6][0], vec_mem[8*i+7][7:0]);
			i++;
		end
		end_test("core decode from file");

		begin_test();
		for (int n = 0; n < rand_count; n++) begin
			v = rand_bits(32);
			v[7] = 1'b1;
			r = ref_map(v[7:0], v[23:8], v[31:24], ~v[15:8]);
			run_core_vector(v[7:0], v[23:8], v[31:24], ~v[15:8], r.addr, r.we, r.data);
		end
		end_test("core decode random");

		begin_test();
		next_slot();
		drive_core(8'h88, 16'h1000, 8'h00, 8'h77);
		i = 0;
		while (i < max_vec && vec_mem[8*i] != 32'hf) begin
			if (vec_mem[8*i] == 32'h1)
				run_load_vector(vec_mem[8*i+3][7:0], vec_mem[8*i+2][24:0],
					vec_mem[8*i+4][7:0], vec_mem[8*i+5][24:0], vec_mem[8*i+6][0],
					vec_mem[8*i+7][7:0]);
			i++;
		end
		@(posedge clk_48m);
		ioctl_download <= 1'b0;
		mem_we <= 1'b0;
		end_test("download");

		begin_test();
		wait_cpu_reset(1'b0, bbc_mem_pkg::remap_hold + 100);
		@(posedge clk_48m);
		model <= ~model;
		repeat (4000) @(posedge clk_48m);
		@(negedge clk_48m);
		check_we("cpu_reset", cpu_reset, 1'b1);
		repeat (110) @(posedge clk_48m);
		@(negedge clk_48m);
		check_we("cpu_reset", cpu_reset, 1'b0);
		end_test("remap hold");

		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* verification/bbc_mem_testdata.txt */
// kind(0 core, 1 download, f end) flags addr romsel_or_index data exp_addr exp_we exp_data
// flags: 80 phi0, 40 acc_y, 20 shadow_ram, 10 shadow_vid, 08 we, 02 master, 01 rommap
0 18 3000 00 5a 13000 0 5a
0 88 1234 00 a5 01234 1 a5
0 a8 3456 00 11 13456 1 11
0 88 8123 80 22 08123 1 22
0 c8 c456 00 33 0a456 1 33
0 88 e000 00 44 82000 0 44
0 8a fffc 00 55 87ffc 0 55
0 89 9abc 03 66 9dabc 0 66
0 88 a001 0e 77 9a001 0 77
0 8a b123 09 88 c7123 0 88
0 8a 8010 02 99 a8010 0 99
0 89 9000 05 aa 55000 1 aa
0 88 8100 00 bb 40100 0 bb
0 8a bfff 05 cc 57fff 1 cc
1 00 01234 00 3c 81234 1 3c
1 00 00010 40 c3 68010 1 c3
1 00 00020 ff 5e 00000 0 5e
f 0 0 0 0 0 0 0

/* list.f */
rtl/bbc_mem_pkg.sv
rtl/cpu_bus_if.sv
rtl/cpu_addr_map.sv
rtl/rom_loader.sv
rtl/sdram_request_port.sv
rtl/reset_sequencer.sv
rtl/bbc_mem_top.sv
verification/tb_clock_gen.sv
verification/bbc_mem_sva.sv
verification/bbc_mem_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the bbc_mem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module bbc_mem_tb -f list.f -o Vbbc_mem_tb
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vbbc_mem_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "PASS: all tests" "$log"; then
	exit 0
else
	echo "pass message not found in $log"
	exit 1
fi
